// File: hdl/spdif_defines.svh
/*
 * S/PDIF transmitter constants: FIFO geometry, block and subframe sizes, bit-depth codes.
 */
`ifndef SPDIF_DEFINES_SVH
`define SPDIF_DEFINES_SVH

// ====================
// Byte FIFO geometry
// ====================
// The depth must stay a power of two so the wrap bit of each pointer works.
`define SPDIF_FIFO_DEPTH 16
`define SPDIF_FIFO_AW 4

// ====================
// IEC 60958 framing
// ====================
// One block is 192 frames, which is 384 subframes.
`define SPDIF_BLOCK_SUBFRAMES 384
// Time slots per subframe. Each slot is two half-cells on the line.
`define SPDIF_SLOTS 32
// Width of the audio field that follows the 4-slot preamble.
`define SPDIF_AUDIO_BITS 24

// ====================
// Bit-depth codes
// ====================
`define SPDIF_BIT_DEPTH_16 2'd0
`define SPDIF_BIT_DEPTH_24 2'd1
`define SPDIF_BIT_DEPTH_DOP 2'd2
// Any stream with this code is not accepted by the assembler.
`define SPDIF_BIT_DEPTH_INVALID 2'd3

`endif

// File: hdl/spdif_pkg.sv
/*
 * Types shared by the S/PDIF transmitter: subframe layout, bit depth and preamble selection.
 */
`include "spdif_defines.svh"

package spdif_pkg;

    // DoP is framed exactly like 24-bit PCM.
    typedef enum logic [1:0] {
        BIT_DEPTH_16      = `SPDIF_BIT_DEPTH_16,
        BIT_DEPTH_24      = `SPDIF_BIT_DEPTH_24,
        BIT_DEPTH_DOP     = `SPDIF_BIT_DEPTH_DOP,
        BIT_DEPTH_INVALID = `SPDIF_BIT_DEPTH_INVALID
    } bit_depth_e;

    // Bit 0 of the struct is the first audio bit on the line. The fields that follow
    // the audio go out in the order V, U, C and P, so slot n of the subframe is bit n - 4.
    typedef struct packed {
        logic                          parity;
        logic                          channel_status;
        logic                          user;
        logic                          validity;
        logic [`SPDIF_AUDIO_BITS-1:0]  audio;
    } subframe_t;

    // B opens a block, M marks the other left subframes and W marks every right subframe.
    typedef enum logic [1:0] {
        PRE_B,
        PRE_M,
        PRE_W
    } preamble_e;

    // Returns the eight preamble half-cells, bit 7 first on the line.
    // The first half-cell always inverts the level the line was left at.
    function automatic logic [7:0] preamble_pattern(preamble_e pre, logic line_level);
        logic [7:0] pat;
        case (pre)
            PRE_B:   pat = line_level ? 8'b00010111 : 8'b11101000;
            PRE_M:   pat = line_level ? 8'b00011101 : 8'b11100010;
            default: pat = line_level ? 8'b00011011 : 8'b11100100;
        endcase
        return pat;
    endfunction

endpackage

// File: hdl/byte_fifo.sv
/*
 * Synchronous byte FIFO for the S/PDIF transmitter.
 * First-word fall-through read port with full and empty flags.
 */
`timescale 1ns/1ps
`include "spdif_defines.svh"

module byte_fifo (
    input  logic       byte_clk_i,
    input  logic       reset_i,
    input  logic       wr_en_i,
    input  logic [7:0] wr_data_i,
    output logic       full_o,
    input  logic       rd_en_i,
    output logic [7:0] rd_data_o,
    output logic       empty_o
);

    localparam int AW = `SPDIF_FIFO_AW;

    // Storage array. Only the entries between the two pointers hold valid bytes.
    logic [7:0]  mem [`SPDIF_FIFO_DEPTH];

    // Both pointers carry one extra wrap bit above the address.
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_write;
    logic        do_read;

    // Same address with different wrap bits means the writer is a full lap ahead.
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty_o = (wr_ptr == rd_ptr);

    // Writes into a full FIFO and reads from an empty one are dropped here.
    assign do_write = wr_en_i && !full_o;
    assign do_read  = rd_en_i && !empty_o;

    // The head entry is always visible, so a reader sees the byte before it pops it.
    assign rd_data_o = mem[rd_ptr[AW-1:0]];

    // ====================
    // Storage write
    // ====================
    always_ff @(posedge byte_clk_i) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= wr_data_i;
        end
    end

    // ====================
    // Pointers
    // ====================
    always_ff @(posedge byte_clk_i or posedge reset_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: hdl/sample_assembler.sv
/*
 * S/PDIF sample assembler. Pops 2 or 3 bytes per channel sample, builds the subframe
 * with its parity bit and offers it to the encoder on a four-phase handshake.
 */
`timescale 1ns/1ps

module sample_assembler (
    input  logic                   byte_clk_i,
    input  logic                   reset_i,
    input  spdif_pkg::bit_depth_e  bit_depth_i,
    input  logic [7:0]             rd_data_i,
    input  logic                   empty_i,
    output logic                   rd_en_o,
    output logic                   sf_req_o,
    output spdif_pkg::subframe_t   sf_data_o,
    input  logic                   sf_ack_i,
    output logic                   active_o
);

    import spdif_pkg::*;

    // Number of bytes of the current sample already popped.
    logic [1:0] byte_idx;
    // Set when the build register holds a complete subframe not yet handed over.
    logic       sample_done;
    // Subframe under construction. Its parity field is the running parity.
    subframe_t  sf_build;
    subframe_t  build_next;

    logic       depth_ok;
    logic       last_byte;
    logic       is_16;
    logic [1:0] lane;
    logic       handoff;

    // ====================
    // Byte sequencing
    // ====================
    // A 16-bit sample takes two bytes and a 24-bit or DoP sample takes three.
    // The invalid code keeps the assembler from popping anything.
    always_comb begin
        depth_ok  = 1'b1;
        last_byte = 1'b0;
        is_16     = 1'b0;
        case (bit_depth_i)
            BIT_DEPTH_16: begin
                is_16     = 1'b1;
                last_byte = (byte_idx == 2'd1);
            end
            BIT_DEPTH_24, BIT_DEPTH_DOP: begin
                last_byte = (byte_idx == 2'd2);
            end
            default: begin
                depth_ok = 1'b0;
            end
        endcase
    end

    // Pop only while there is room to finish the sample in the build register.
    assign rd_en_o = depth_ok && !empty_i && !sample_done;

    // 16-bit samples are left-justified in the 24-bit field, so their bytes start at lane 1.
    assign lane = byte_idx + {1'b0, is_16};

    // Next value of the build register if the head byte is popped this cycle.
    always_comb begin
        build_next = sf_build;
        if (byte_idx == 2'd0) begin
            // A new sample starts with a clean field. V, U and C stay zero.
            build_next = '0;
        end
        build_next.audio[{lane, 3'b000} +: 8] = rd_data_i;
        // Parity builds up one byte at a time, as each byte arrives.
        build_next.parity = build_next.parity ^ (^rd_data_i);
    end

    // The output slot is free once the previous handshake has fully closed.
    assign handoff = sample_done && !sf_req_o && !sf_ack_i;

    // ====================
    // Control state
    // ====================
    always_ff @(posedge byte_clk_i or posedge reset_i) begin
        if (reset_i) begin
            byte_idx    <= 2'd0;
            sample_done <= 1'b0;
            sf_req_o    <= 1'b0;
            active_o    <= 1'b0;
        end else begin
            if (rd_en_o) begin
                if (last_byte) begin
                    byte_idx    <= 2'd0;
                    sample_done <= 1'b1;
                end else begin
                    byte_idx <= byte_idx + 2'd1;
                end
            end else if (handoff) begin
                sample_done <= 1'b0;
            end

            // Four-phase handshake. Request rises on handoff and falls once acknowledged.
            if (handoff) begin
                sf_req_o <= 1'b1;
            end else if (sf_ack_i) begin
                sf_req_o <= 1'b0;
            end

            // The stream is live from the first pop until nothing is left anywhere here.
            if (rd_en_o) begin
                active_o <= 1'b1;
            end else if (empty_i && byte_idx == 2'd0 && !sample_done && !sf_req_o) begin
                active_o <= 1'b0;
            end
        end
    end

    // ====================
    // Payload registers
    // ====================
    always_ff @(posedge byte_clk_i) begin
        if (rd_en_o) begin
            sf_build <= build_next;
        end
        // Held stable for the whole time the request is up.
        if (handoff) begin
            sf_data_o <= sf_build;
        end
    end

endmodule

// File: hdl/bmc_encoder.sv
/*
 * S/PDIF biphase-mark encoder. Sends one 64 half-cell subframe per request,
 * choosing B, M or W preambles and counting subframes within a block.
 */
`timescale 1ns/1ps
`include "spdif_defines.svh"

module bmc_encoder (
    input  logic                  byte_clk_i,
    input  logic                  reset_i,
    input  logic                  sf_req_i,
    input  spdif_pkg::subframe_t  sf_data_i,
    output logic                  sf_ack_o,
    output logic                  busy_o,
    output logic                  spdif_o
);

    import spdif_pkg::*;

    // One clock cycle is one half-cell on the line.
    localparam int HALF_CELLS = 2 * `SPDIF_SLOTS;
    localparam int HC_W       = $clog2(HALF_CELLS);
    localparam int PRE_CELLS  = 8;
    // Last half-cell of the audio field, after which V, U, C and P follow.
    localparam int AUDIO_END  = PRE_CELLS + 2 * `SPDIF_AUDIO_BITS - 1;
    localparam int CNT_W      = $clog2(`SPDIF_BLOCK_SUBFRAMES);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA,
        ST_CONTROL
    } state_e;

    state_e            state;
    // Index of the half-cell driven on the next clock edge.
    logic [HC_W-1:0]   half_cell;
    // Index within the block of the next subframe to start.
    logic [CNT_W-1:0]  sf_count;
    logic [7:0]        pre_pat;
    subframe_t         sf_latch;

    logic              boundary;
    logic              start_sf;
    preamble_e         pre_sel;
    logic [7:0]        start_pat;
    logic [HC_W-2:0]   bit_idx;
    logic              data_bit;

    // The counter wraps to zero after the last control half-cell, and that edge
    // opens the next subframe. In idle every edge is a possible start.
    assign boundary = (state == ST_IDLE) || (state == ST_CONTROL && half_cell == '0);

    // A request still up while our ack is high is the one already taken.
    assign start_sf = boundary && sf_req_i && !sf_ack_o;

    // Even counts are left channel, odd counts right. Count zero opens the block.
    assign pre_sel   = (sf_count == '0) ? PRE_B : (sf_count[0] ? PRE_W : PRE_M);
    assign start_pat = preamble_pattern(pre_sel, spdif_o);

    // Slot number minus the four preamble slots gives the subframe bit.
    assign bit_idx  = half_cell[HC_W-1:1] - (HC_W-1)'(PRE_CELLS / 2);
    assign data_bit = sf_latch[bit_idx];

    assign busy_o = (state != ST_IDLE);

    // ====================
    // Line FSM
    // ====================
    always_ff @(posedge byte_clk_i or posedge reset_i) begin
        if (reset_i) begin
            state     <= ST_IDLE;
            half_cell <= '0;
            sf_count  <= '0;
            sf_ack_o  <= 1'b0;
            spdif_o   <= 1'b1;
        end else begin
            // Ack rises when the subframe is latched and drops after the request does.
            if (start_sf) begin
                sf_ack_o <= 1'b1;
            end else if (!sf_req_i) begin
                sf_ack_o <= 1'b0;
            end

            if (boundary) begin
                if (start_sf) begin
                    state     <= ST_PREAMBLE;
                    half_cell <= HC_W'(1);
                    spdif_o   <= start_pat[7];
                    if (sf_count == CNT_W'(`SPDIF_BLOCK_SUBFRAMES - 1)) begin
                        sf_count <= '0;
                    end else begin
                        sf_count <= sf_count + 1'b1;
                    end
                end else begin
                    // No data at the boundary ends the stream. The line keeps its level.
                    state     <= ST_IDLE;
                    half_cell <= '0;
                    sf_count  <= '0;
                end
            end else begin
                half_cell <= half_cell + 1'b1;
                case (state)
                    ST_PREAMBLE: begin
                        spdif_o <= pre_pat[3'd7 - half_cell[2:0]];
                        if (half_cell == HC_W'(PRE_CELLS - 1)) begin
                            state <= ST_DATA;
                        end
                    end
                    ST_DATA, ST_CONTROL: begin
                        // Every slot opens with a transition; a one adds another mid-slot.
                        if (!half_cell[0]) begin
                            spdif_o <= ~spdif_o;
                        end else begin
                            spdif_o <= spdif_o ^ data_bit;
                        end
                        if (state == ST_DATA && half_cell == HC_W'(AUDIO_END)) begin
                            state <= ST_CONTROL;
                        end
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    // ====================
    // Subframe latch
    // ====================
    always_ff @(posedge byte_clk_i) begin
        if (start_sf) begin
            sf_latch <= sf_data_i;
            pre_pat  <= start_pat;
        end
    end

endmodule

// File: hdl/spdif_tx.sv
/*
 * S/PDIF transmitter top level. Chains the byte FIFO, the sample assembler and the encoder.
 */
`timescale 1ns/1ps

module spdif_tx (
    input  logic                   byte_clk_i,
    input  logic                   reset_i,
    input  spdif_pkg::bit_depth_e  bit_depth_i,
    input  logic                   wr_en_i,
    input  logic [7:0]             wr_data_i,
    output logic                   full_o,
    output logic                   streaming_o,
    output logic                   spdif_o
);

    import spdif_pkg::*;

    // FIFO read port.
    logic [7:0] rd_data;
    logic       rd_en;
    logic       empty;

    // Subframe handshake between assembler and encoder.
    logic       sf_req;
    subframe_t  sf_data;
    logic       sf_ack;

    logic       asm_active;
    logic       enc_busy;

    byte_fifo byte_fifo_inst (
        .byte_clk_i (byte_clk_i),
        .reset_i    (reset_i),
        .wr_en_i    (wr_en_i),
        .wr_data_i  (wr_data_i),
        .full_o     (full_o),
        .rd_en_i    (rd_en),
        .rd_data_o  (rd_data),
        .empty_o    (empty)
    );

    sample_assembler sample_assembler_inst (
        .byte_clk_i  (byte_clk_i),
        .reset_i     (reset_i),
        .bit_depth_i (bit_depth_i),
        .rd_data_i   (rd_data),
        .empty_i     (empty),
        .rd_en_o     (rd_en),
        .sf_req_o    (sf_req),
        .sf_data_o   (sf_data),
        .sf_ack_i    (sf_ack),
        .active_o    (asm_active)
    );

    bmc_encoder bmc_encoder_inst (
        .byte_clk_i (byte_clk_i),
        .reset_i    (reset_i),
        .sf_req_i   (sf_req),
        .sf_data_i  (sf_data),
        .sf_ack_o   (sf_ack),
        .busy_o     (enc_busy),
        .spdif_o    (spdif_o)
    );

    // The assembler covers the stream start and the encoder covers the tail.
    assign streaming_o = asm_active | enc_busy;

endmodule

// File: verification/spdif_tx_sva.sv
/*
 * Assertions on the subframe handshake and on biphase-mark line coding.
 */
`timescale 1ns/1ps

module spdif_tx_sva (
    input logic                  byte_clk_i,
    input logic                  reset_i,
    input logic                  sf_req_i,
    input spdif_pkg::subframe_t  sf_data_i,
    input logic                  sf_ack_i,
    input logic                  busy_i,
    input logic [5:0]            half_cell_i,
    input logic                  spdif_i
);

    // A request is only withdrawn after the encoder has answered it.
    req_held_a: assert property (@(posedge byte_clk_i) disable iff (reset_i)
        sf_req_i && !sf_ack_i |=> sf_req_i)
        else $error("sf_req fell before sf_ack rose");

    // The payload stays put while the request is up.
    data_stable_a: assert property (@(posedge byte_clk_i) disable iff (reset_i)
        sf_req_i && $past(sf_req_i) |-> $stable(sf_data_i))
        else $error("sf_data changed while sf_req was high");

    ack_held_a: assert property (@(posedge byte_clk_i) disable iff (reset_i)
        sf_ack_i && sf_req_i |=> sf_ack_i)
        else $error("sf_ack fell before sf_req fell");

    // Past the preamble, each even half-cell opens a slot with a transition.
    slot_edge_a: assert property (@(posedge byte_clk_i) disable iff (reset_i)
        busy_i && half_cell_i >= 6'd8 && !half_cell_i[0] |=> spdif_i != $past(spdif_i))
        else $error("spdif_o did not toggle at the start of a slot");

endmodule

// File: verification/spdif_tx_tb.sv
/*
 * Testbench for the S/PDIF transmitter. Streams table samples through the DUT,
 * decodes the biphase-mark line and checks audio, V/U/C, parity, preambles and idle.
 */
`timescale 1ns/1ps
`include "spdif_defines.svh"

module spdif_tx_tb;

    import spdif_pkg::*;

    localparam int NUM_TESTS     = 5;
    localparam int TOTAL_SAMPLES = 454;
    localparam int IDLE_CYCLES   = 80;

    // Preambles as sent after a low line. After a high line all eight half-cells invert.
    localparam logic [7:0] PAT_B = 8'b11101000;
    localparam logic [7:0] PAT_M = 8'b11100010;
    localparam logic [7:0] PAT_W = 8'b11100100;

    typedef struct packed {
        bit_depth_e  depth;
        logic [15:0] samples;
        logic        want_full;
    } test_t;

    typedef struct packed {
        logic [23:0] data;
        logic [23:0] expected;
    } sample_t;

    logic        byte_clk_i;
    logic        reset_i;
    bit_depth_e  bit_depth_i;
    logic        wr_en_i;
    logic [7:0]  wr_data_i;
    logic        full_o;
    logic        streaming_o;
    logic        spdif_o;

    test_t       test_tab [NUM_TESTS];
    sample_t     smp_tab [TOTAL_SAMPLES];
    logic [23:0] exp_q [$];

    int          error_count;
    int          pass_count;
    int          fail_count;
    int          watchdog_cycles;
    logic        saw_full;

    // Line decoder state. Cell 0 is the first half-cell of the preamble.
    logic        cells [2 * `SPDIF_SLOTS];
    int          hc_cnt;
    int          block_idx;
    int          decoded_count;
    logic        prev_level;
    logic        start_level;
    logic        just_ended;

    spdif_tx spdif_tx_inst (
        .byte_clk_i  (byte_clk_i),
        .reset_i     (reset_i),
        .bit_depth_i (bit_depth_i),
        .wr_en_i     (wr_en_i),
        .wr_data_i   (wr_data_i),
        .full_o      (full_o),
        .streaming_o (streaming_o),
        .spdif_o     (spdif_o)
    );

    // Handshake and line-coding assertions live inside the encoder.
    bind bmc_encoder spdif_tx_sva spdif_tx_sva_inst (
        .byte_clk_i  (byte_clk_i),
        .reset_i     (reset_i),
        .sf_req_i    (sf_req_i),
        .sf_data_i   (sf_data_i),
        .sf_ack_i    (sf_ack_o),
        .busy_i      (busy_o),
        .half_cell_i (half_cell),
        .spdif_i     (spdif_o)
    );

    always #2 byte_clk_i = ~byte_clk_i;

    function automatic string depth_label(bit_depth_e depth);
        case (depth)
            BIT_DEPTH_16:  return "16-bit";
            BIT_DEPTH_24:  return "24-bit";
            BIT_DEPTH_DOP: return "DoP";
            default:       return "invalid";
        endcase
    endfunction

    // ====================
    // Subframe checker
    // ====================
    task automatic check_subframe();
        logic [7:0]  pre_raw;
        logic [7:0]  pre_exp;
        logic [27:0] bits;
        logic [23:0] exp_audio;
        logic        coding_ok;
        int          k;
        coding_ok = 1'b1;
        for (k = 0; k < 8; k++) begin
            pre_raw[7 - k] = cells[k];
        end
        // B opens the block, then right subframes get W and left ones get M.
        if (block_idx == 0) begin
            pre_exp = PAT_B;
        end else if (block_idx % 2 == 1) begin
            pre_exp = PAT_W;
        end else begin
            pre_exp = PAT_M;
        end
        if (start_level) begin
            pre_exp = ~pre_exp;
        end
        if (pre_raw != pre_exp) begin
            $display("[FAIL] spdif_o preamble (block index %0d): expected 0x%02h, actual 0x%02h",
                     block_idx, pre_exp, pre_raw);
            error_count++;
        end
        // Slot k starts at half-cell 8 + 2k. A change in mid-slot encodes a one.
        for (k = 0; k < 28; k++) begin
            if (cells[8 + 2 * k] == cells[7 + 2 * k]) begin
                coding_ok = 1'b0;
            end
            bits[k] = cells[8 + 2 * k] ^ cells[9 + 2 * k];
        end
        if (!coding_ok) begin
            $display("Subframe %0d has a slot that does not start with a line transition.",
                     decoded_count);
            error_count++;
        end
        if (exp_q.size() == 0) begin
            $display("A subframe was decoded while no sample was pending.");
            error_count++;
        end else begin
            exp_audio = exp_q.pop_front();
            if (bits[23:0] != exp_audio) begin
                $display("[FAIL] spdif_o audio (subframe %0d): expected 0x%06h, actual 0x%06h",
                         decoded_count, exp_audio, bits[23:0]);
                error_count++;
            end
        end
        if (bits[26:24] != 3'b000) begin
            $display("[FAIL] spdif_o V/U/C: expected 0x0, actual 0x%01h", bits[26:24]);
            error_count++;
        end
        if (^bits != 1'b0) begin
            $display("[FAIL] spdif_o parity of slots 4-31: expected 0x0, actual 0x1");
            error_count++;
        end
        decoded_count++;
        block_idx = (block_idx + 1) % `SPDIF_BLOCK_SUBFRAMES;
    endtask

    // ====================
    // Line decoder
    // ====================
    // The line is sampled in mid-cycle, away from the edge that changes it.
    always @(negedge byte_clk_i) begin
        if (reset_i) begin
            hc_cnt     = 0;
            block_idx  = 0;
            just_ended = 1'b0;
        end else if (hc_cnt == 0) begin
            // Every preamble opens with a transition. If none follows a subframe at once,
            // the stream has stopped and the next one must restart the block.
            if (spdif_o != prev_level) begin
                if (!just_ended) begin
                    block_idx = 0;
                end
                start_level = prev_level;
                cells[0]    = spdif_o;
                hc_cnt      = 1;
            end
            just_ended = 1'b0;
        end else begin
            cells[hc_cnt] = spdif_o;
            hc_cnt        = hc_cnt + 1;
            if (hc_cnt == 2 * `SPDIF_SLOTS) begin
                check_subframe();
                hc_cnt     = 0;
                just_ended = 1'b1;
            end
        end
        prev_level = spdif_o;
    end

    // Holds one byte on the write port until the FIFO has room for it.
    task automatic write_byte(input logic [7:0] value);
        @(posedge byte_clk_i);
        wr_en_i   <= 1'b1;
        wr_data_i <= value;
        @(negedge byte_clk_i);
        while (full_o) begin
            saw_full = 1'b1;
            @(negedge byte_clk_i);
        end
    endtask

    task automatic run_test(input int t, input int base);
        int      i;
        int      errors_before;
        logic    level;
        logic    idle_ok;
        sample_t s;
        errors_before = error_count;
        saw_full      = 1'b0;
        decoded_count = 0;
        idle_ok       = 1'b1;
        @(posedge byte_clk_i);
        bit_depth_i <= test_tab[t].depth;
        for (i = 0; i < test_tab[t].samples; i++) begin
            s = smp_tab[base + i];
            exp_q.push_back(s.expected);
            write_byte(s.data[7:0]);
            write_byte(s.data[15:8]);
            if (test_tab[t].depth != BIT_DEPTH_16) begin
                write_byte(s.data[23:16]);
            end
        end
        @(posedge byte_clk_i);
        wr_en_i <= 1'b0;
        // The stream is over once the encoder has run dry and gone idle.
        @(negedge byte_clk_i);
        while (streaming_o) begin
            @(negedge byte_clk_i);
        end
        level = spdif_o;
        repeat (IDLE_CYCLES) begin
            @(negedge byte_clk_i);
            if (spdif_o != level || streaming_o) begin
                idle_ok = 1'b0;
            end
        end
        if (!idle_ok) begin
            $display("The line or streaming_o moved after the stream had ended.");
            error_count++;
        end
        if (hc_cnt != 0) begin
            $display("The line stopped in the middle of a subframe.");
            error_count++;
        end
        if (decoded_count != test_tab[t].samples) begin
            $display("[FAIL] decoded subframes: expected 0x%0h, actual 0x%0h",
                     test_tab[t].samples, decoded_count);
            error_count++;
        end
        if (test_tab[t].want_full && !saw_full) begin
            $display("full_o never rose during the back-to-back burst.");
            error_count++;
        end
        if (error_count == errors_before) begin
            pass_count++;
            $display("Test %0d (%s, %0d samples) passed", t, depth_label(test_tab[t].depth),
                     test_tab[t].samples);
        end else begin
            fail_count++;
            $display("Test %0d (%s, %0d samples) failed with %0d errors", t,
                     depth_label(test_tab[t].depth), test_tab[t].samples,
                     error_count - errors_before);
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        int t;
        int i;
        int base;
        int limit;
        byte_clk_i      = 1'b0;
        reset_i         = 1'b1;
        bit_depth_i     = BIT_DEPTH_16;
        wr_en_i         = 1'b0;
        wr_data_i       = 8'h00;
        error_count     = 0;
        pass_count      = 0;
        fail_count      = 0;
        saw_full        = 1'b0;
        decoded_count   = 0;
        prev_level      = 1'b1;
        watchdog_cycles = 0;
        void'($urandom(54));
        test_tab[0] = '{depth: BIT_DEPTH_16, samples: 16'd10, want_full: 1'b0};
        test_tab[1] = '{depth: BIT_DEPTH_24, samples: 16'd12, want_full: 1'b0};
        test_tab[2] = '{depth: BIT_DEPTH_DOP, samples: 16'd8, want_full: 1'b0};
        // Longer than one block, so B must come round again at subframe 384.
        test_tab[3] = '{depth: BIT_DEPTH_24, samples: 16'd400, want_full: 1'b0};
        // Back-to-back bytes outrun the encoder and must fill the FIFO.
        test_tab[4] = '{depth: BIT_DEPTH_16, samples: 16'd24, want_full: 1'b1};
        base  = 0;
        limit = 8;
        for (t = 0; t < NUM_TESTS; t++) begin
            for (i = 0; i < test_tab[t].samples; i++) begin
                smp_tab[base + i].data = 24'($urandom());
                if (test_tab[t].depth == BIT_DEPTH_16) begin
                    // Two bytes fill audio bits 8-23 and bits 0-7 stay zero.
                    smp_tab[base + i].data[23:16] = 8'h00;
                    smp_tab[base + i].expected    = {smp_tab[base + i].data[15:0], 8'h00};
                end else begin
                    smp_tab[base + i].expected = smp_tab[base + i].data;
                end
            end
            base  = base + test_tab[t].samples;
            limit = limit + 64 * test_tab[t].samples + 2000;
        end
        watchdog_cycles = limit;
        repeat (8) @(posedge byte_clk_i);
        reset_i <= 1'b0;
        base = 0;
        for (t = 0; t < NUM_TESTS; t++) begin
            run_test(t, base);
            base = base + test_tab[t].samples;
        end
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized from the table once it is filled.
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge byte_clk_i);
        $display("Timeout: the tests did not finish within %0d cycles.", watchdog_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: tb.f
+incdir+hdl
hdl/spdif_pkg.sv
hdl/byte_fifo.sv
hdl/sample_assembler.sv
hdl/bmc_encoder.sv
hdl/spdif_tx.sv
verification/spdif_tx_sva.sv
verification/spdif_tx_tb.sv

// File: run.sh
#!/bin/sh
# Builds the S/PDIF transmitter testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module spdif_tx_tb -f tb.f -o spdif_tx_sim

# A failed assertion stops the simulator early, so the log decides the result.
./obj_dir/spdif_tx_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation reported failures."
    exit 1
fi
if ! grep -q "NO ERRORS" "$LOG"; then
    echo "Simulation ended without a result."
    exit 1
fi
echo "Simulation passed."
